// File: files.f
+incdir+.
wb_pkg.sv
wb_stage.sv
csr_file.sv
reg_file.sv
wb_top.sv
tb_clkgen.sv
wb_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module wb_tb -f files.f -o Vwb_tb
./obj_dir/Vwb_tb | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_tb;
  import wb_pkg::*;

  localparam int  RESET_CYCLES = 10;
  localparam int  N_RAND_WR    = 60;
  localparam int  N_CSR_ROUNDS = 8;
  localparam int  N_EX_RAND    = 20;
  localparam int  N_ERTN       = 8;
  localparam int  N_IDLE       = 40;
  // each test ends with two settle cycles
  localparam int  TEST_CYCLES  = (32 + N_RAND_WR) + N_CSR_ROUNDS * 9 + (16 + N_EX_RAND) * 8
                               + 6 * 8 + N_ERTN * 8 + (N_IDLE + 6) + 6 * 2;
  localparam real TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * 20.0 + 2000.0;

  logic        clk;
  logic        rst_n;
  logic        valid;
  mem_wb_bus_t mem_bus;
  reg_addr_t   ra1;
  reg_addr_t   ra2;
  word_t       rd1;
  word_t       rd2;
  wb_bypass_t  bypass;
  debug_wb_t   debug;
  flush_t      flush;

  // reference model state
  word_t       shadow_rf [32];
  logic        known [32];
  word_t       crmd;
  word_t       prmd;
  word_t       estat;
  word_t       era;
  word_t       badv;
  word_t       eentry;

  // expected outputs of the cycle on the bus
  word_t       exp_rd1;
  word_t       exp_rd2;
  logic        chk_rd1;
  logic        chk_rd2;
  wb_bypass_t  exp_bypass;
  debug_wb_t   exp_debug;
  flush_t      exp_flush;
  logic        exp_ex;
  ecode_t      exp_ecode;
  esubcode_t   exp_esub;
  int          err_count;
  int          test_count;
  int          fail_tests;

  tb_clkgen #(.PERIOD_NS(20.0)) clkgen0 (.clk(clk));

  wb_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (valid),
    .mem_bus (mem_bus),
    .ra1     (ra1),
    .ra2     (ra2),
    .rd1     (rd1),
    .rd2     (rd2),
    .bypass  (bypass),
    .debug   (debug),
    .flush   (flush)
  );

  function automatic word_t csr_model_read(input csr_num_t num);
    case (num)
      `CSR_CRMD:   return crmd;
      `CSR_PRMD:   return prmd;
      `CSR_ESTAT:  return estat;
      `CSR_ERA:    return era;
      `CSR_BADV:   return badv;
      `CSR_EENTRY: return eentry;
      default:     return '0;
    endcase
  endfunction

  // isolate the lowest set bit, its position indexes the code table
  function automatic ecode_t lowest_ecode(input ebus_t eb);
    ecode_t tbl [16];
    ebus_t  onehot;
    tbl = '{`ECODE_INT, `ECODE_PIL, `ECODE_PIS, `ECODE_PIF, `ECODE_PME, `ECODE_PPI,
            `ECODE_ADE, `ECODE_ADE, `ECODE_ALE, `ECODE_SYS, `ECODE_BRK, `ECODE_INE,
            `ECODE_IPE, `ECODE_FPD, `ECODE_FPE, `ECODE_TLBR};
    onehot = eb & (~eb + 16'd1);
    return tbl[4'($clog2(onehot))];
  endfunction

  function automatic csr_num_t pick_csr();
    csr_num_t nums [6];
    nums = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY};
    return nums[3'($urandom % 6)];
  endfunction

  function automatic mem_wb_bus_t plain_bus();
    mem_wb_bus_t b;
    b              = '0;
    b.pc           = $urandom;
    b.final_result = $urandom;
    b.rf_waddr     = reg_addr_t'($urandom);
    return b;
  endfunction

  task automatic csr_model_write(input csr_num_t num, input word_t mask, input word_t val);
    word_t old_val;
    old_val = csr_model_read(num);
    old_val = old_val ^ ((old_val ^ val) & mask);
    case (num)
      `CSR_CRMD:   crmd   = old_val;
      `CSR_PRMD:   prmd   = old_val;
      `CSR_ESTAT:  estat  = old_val;
      `CSR_ERA:    era    = old_val;
      `CSR_BADV:   badv   = old_val;
      `CSR_EENTRY: eentry = old_val;
      default: ;
    endcase
  endtask

  // present one entry, then commit it to the model at the rising edge
  task automatic issue(input logic v, input mem_wb_bus_t b);
    word_t wdata;
    logic  we;
    @(negedge clk);
    valid      = v;
    mem_bus    = b;
    ra1        = reg_addr_t'($urandom);
    ra2        = reg_addr_t'($urandom);
    exp_ex     = v && (b.ebus != '0);
    exp_ecode  = lowest_ecode(b.ebus);
    exp_esub   = ((b.ebus & (~b.ebus + 16'd1)) == (16'd1 << `EBUS_ADEM)) ? `ESUBCODE_ADEM : '0;
    wdata      = b.res_from_csr ? csr_model_read(b.csr_ctrl.num) : b.final_result;
    we         = v && b.rf_we && !exp_ex;
    exp_bypass = '{res_from_csr: b.res_from_csr, waddr: b.rf_waddr, we: we, wdata: wdata};
    exp_debug  = '{pc: b.pc, rf_we: {4{we}}, wnum: b.rf_waddr, wdata: wdata};
    exp_flush  = '{valid: exp_ex || (v && b.ertn), target: exp_ex ? eentry : era};
    exp_rd1    = shadow_rf[ra1];
    exp_rd2    = shadow_rf[ra2];
    chk_rd1    = known[ra1];
    chk_rd2    = known[ra2];
    @(posedge clk);
    if (we && b.rf_waddr != '0) begin
      shadow_rf[b.rf_waddr] = wdata;
      known[b.rf_waddr]     = 1'b1;
    end
    if (exp_ex) begin
      prmd[`CSR_PLV_IE]      = crmd[`CSR_PLV_IE];
      crmd[`CSR_PLV_IE]      = '0;
      estat[`ESTAT_ECODE]    = exp_ecode;
      estat[`ESTAT_ESUBCODE] = exp_esub;
      era                    = b.pc;
      if (exp_ecode inside {`ECODE_ADE, `ECODE_ALE}) begin
        badv = b.final_result;
      end
    end else begin
      if (v && b.csr_ctrl.we) begin
        csr_model_write(b.csr_ctrl.num, b.csr_ctrl.wmask, b.csr_ctrl.wvalue);
      end
      if (v && b.ertn) begin
        crmd[`CSR_PLV_IE] = prmd[`CSR_PLV_IE];
      end
    end
  endtask

  task automatic write_csr(input csr_num_t num, input word_t mask, input word_t val);
    mem_wb_bus_t b;
    b          = plain_bus();
    b.csr_ctrl = '{num: num, we: 1'b1, wmask: mask, wvalue: val};
    issue(1'b1, b);
  endtask

  task automatic read_csr(input csr_num_t num);
    mem_wb_bus_t b;
    b              = plain_bus();
    b.rf_we        = 1'b1;
    b.res_from_csr = 1'b1;
    b.csr_ctrl.num = num;
    issue(1'b1, b);
  endtask

  task automatic read_all_csrs();
    read_csr(`CSR_CRMD);
    read_csr(`CSR_PRMD);
    read_csr(`CSR_ESTAT);
    read_csr(`CSR_ERA);
    read_csr(`CSR_BADV);
    read_csr(`CSR_EENTRY);
  endtask

  // raise plv and ie first so the entry has something to clear
  task automatic exception_round(input ebus_t eb);
    mem_wb_bus_t b;
    write_csr(`CSR_CRMD, 32'h7, 32'h7);
    b          = plain_bus();
    b.ebus     = eb;
    b.rf_we    = 1'b1;
    b.csr_ctrl = '{num: pick_csr(), we: 1'b1, wmask: $urandom, wvalue: $urandom};
    issue(1'b1, b);
    read_all_csrs();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int n;
    issue(1'b0, '0);
    @(negedge clk);
    n          = err_count - errs_before;
    test_count = test_count + 1;
    if (n != 0) begin
      fail_tests = fail_tests + 1;
    end
    $display("test %0d %s: %s (%0d mismatches)", test_count, name,
             (n == 0) ? "passed" : "failed", n);
  endtask

  a_rd1: assert property (@(posedge clk) disable iff (!rst_n) !chk_rd1 || rd1 == exp_rd1)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: rd1 got %h, expected %h", $time, $sampled(rd1), exp_rd1);
    end

  a_rd2: assert property (@(posedge clk) disable iff (!rst_n) !chk_rd2 || rd2 == exp_rd2)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: rd2 got %h, expected %h", $time, $sampled(rd2), exp_rd2);
    end

  a_bypass: assert property (@(posedge clk) disable iff (!rst_n) !valid || bypass == exp_bypass)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: bypass got %h, expected %h", $time, $sampled(bypass),
               exp_bypass);
    end

  a_debug: assert property (@(posedge clk) disable iff (!rst_n) !valid || debug == exp_debug)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: debug got %h, expected %h", $time, $sampled(debug), exp_debug);
    end

  a_flush_valid: assert property (@(posedge clk) disable iff (!rst_n)
    flush.valid == exp_flush.valid)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: flush valid got %b, expected %b", $time,
               $sampled(flush.valid), exp_flush.valid);
    end

  a_flush_target: assert property (@(posedge clk) disable iff (!rst_n)
    !exp_flush.valid || flush.target == exp_flush.target)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: flush target got %h, expected %h", $time,
               $sampled(flush.target), exp_flush.target);
    end

  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    valid || (debug.rf_we == 4'b0 && !bypass.we))
    else begin
      err_count = err_count + 1;
      $display("MISMATCH at %0t: write enable seen with valid low", $time);
    end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0t", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int          errs;
    mem_wb_bus_t b;
    void'($urandom(32'hc029b02d));
    rst_n      = 1'b0;
    valid      = 1'b0;
    mem_bus    = '0;
    ra1        = '0;
    ra2        = '0;
    shadow_rf  = '{default: '0};
    known      = '{default: 1'b0};
    known[0]   = 1'b1;
    crmd       = '0;
    prmd       = '0;
    estat      = '0;
    era        = '0;
    badv       = '0;
    eentry     = '0;
    exp_rd1    = '0;
    exp_rd2    = '0;
    chk_rd1    = 1'b0;
    chk_rd2    = 1'b0;
    exp_bypass = '0;
    exp_debug  = '0;
    exp_flush  = '0;
    exp_ex     = 1'b0;
    exp_ecode  = '0;
    exp_esub   = '0;
    err_count  = 0;
    test_count = 0;
    fail_tests = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    errs = err_count;
    for (int i = 0; i < 32 + N_RAND_WR; i++) begin
      b          = plain_bus();
      b.rf_we    = 1'b1;
      b.rf_waddr = (i < 32) ? reg_addr_t'(i) : reg_addr_t'($urandom);
      issue(1'b1, b);
    end
    finish_test("plain writeback and r0", errs);

    errs = err_count;
    for (int i = 0; i < N_CSR_ROUNDS; i++) begin
      write_csr(`CSR_EENTRY, $urandom, $urandom);
      write_csr(`CSR_PRMD, $urandom, $urandom);
      write_csr(pick_csr(), $urandom, $urandom);
      read_all_csrs();
    end
    finish_test("csr read and masked write", errs);

    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      exception_round(ebus_t'(16'd1 << i));
    end
    for (int i = 0; i < N_EX_RAND; i++) begin
      exception_round(ebus_t'($urandom) | ebus_t'(16'd1 << ($urandom % 16)));
    end
    finish_test("exception entry", errs);

    errs = err_count;
    for (int i = 0; i < 2; i++) begin
      exception_round(ebus_t'(16'd1 << `EBUS_ADEM));
      exception_round(ebus_t'(16'd1 << `EBUS_ALE));
      exception_round(ebus_t'(16'd1 << `EBUS_ADEF));
    end
    finish_test("address faults", errs);

    errs = err_count;
    for (int i = 0; i < N_ERTN; i++) begin
      write_csr(`CSR_PRMD, 32'h7, $urandom);
      write_csr(`CSR_ERA, 32'hffff_ffff, $urandom);
      write_csr(`CSR_CRMD, 32'h7, 32'h0);
      b      = plain_bus();
      b.ertn = 1'b1;
      issue(1'b1, b);
      read_csr(`CSR_CRMD);
      // an ertn with a fault takes the exception path
      b.ebus = ebus_t'(16'd1 << ($urandom % 16));
      issue(1'b1, b);
      read_csr(`CSR_CRMD);
      read_csr(`CSR_ERA);
    end
    finish_test("return from exception", errs);

    errs = err_count;
    for (int i = 0; i < N_IDLE; i++) begin
      b              = plain_bus();
      b.ebus         = ebus_t'($urandom);
      b.ertn         = 1'($urandom);
      b.rf_we        = 1'($urandom);
      b.res_from_csr = 1'($urandom);
      b.csr_ctrl     = '{num: pick_csr(), we: 1'($urandom), wmask: $urandom, wvalue: $urandom};
      issue(1'b0, b);
    end
    read_all_csrs();
    finish_test("invalid cycles", errs);

    $display("%0d tests run, %0d failed, %0d mismatches", test_count, fail_tests, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                valid,
  input  wire wb_pkg::mem_wb_bus_t mem_bus,
  input  wire wb_pkg::reg_addr_t   ra1,
  input  wire wb_pkg::reg_addr_t   ra2,
  output wb_pkg::word_t            rd1,
  output wb_pkg::word_t            rd2,
  output wb_pkg::wb_bypass_t       bypass,
  output wb_pkg::debug_wb_t        debug,
  output wb_pkg::flush_t           flush
);
  import wb_pkg::*;

  rf_wr_t  rf_wr;
  wb_csr_t csr_req;
  word_t   csr_rvalue;

  wb_stage u_wb_stage (
    .valid      (valid),
    .mem_bus    (mem_bus),
    .csr_rvalue (csr_rvalue),
    .rf_wr      (rf_wr),
    .bypass     (bypass),
    .debug      (debug),
    .csr_req    (csr_req)
  );

  csr_file u_csr_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_req    (csr_req),
    .csr_rvalue (csr_rvalue),
    .flush      (flush)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .rf_wr (rf_wr),
    .ra1   (ra1),
    .ra2   (ra2),
    .rd1   (rd1),
    .rd2   (rd2)
  );

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module reg_file (
  input  wire logic              clk,
  input  wire wb_pkg::rf_wr_t    rf_wr,
  input  wire wb_pkg::reg_addr_t ra1,
  input  wire wb_pkg::reg_addr_t ra2,
  output wb_pkg::word_t          rd1,
  output wb_pkg::word_t          rd2
);
  import wb_pkg::*;

  // r0 has no storage
  word_t regs [1:`RF_DEPTH-1];

  always_ff @(posedge clk) begin
    if (rf_wr.we && rf_wr.waddr != '0) begin
      regs[rf_wr.waddr] <= rf_wr.wdata;
    end
  end

  // no write-through, bypass covers that
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module csr_file (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire wb_pkg::wb_csr_t csr_req,
  output wb_pkg::word_t        csr_rvalue,
  output wb_pkg::flush_t       flush
);
  import wb_pkg::*;

  word_t    crmd;
  word_t    prmd;
  word_t    estat;
  word_t    era;
  word_t    badv;
  word_t    eentry;
  logic     wr_en;
  logic     badv_we;
  csr_num_t num;
  word_t    wmask;
  word_t    wvalue;

  function automatic word_t merge(input word_t old_val, input word_t mask,
                                  input word_t new_val);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  assign num    = csr_req.csr_ctrl.num;
  assign wmask  = csr_req.csr_ctrl.wmask;
  assign wvalue = csr_req.csr_ctrl.wvalue;

  // exception wins over a write
  assign wr_en = csr_req.csr_ctrl.we & ~csr_req.ex;

  assign badv_we = csr_req.ex &
                   (csr_req.ecode == `ECODE_ADE || csr_req.ecode == `ECODE_ALE);

  // read port
  always_comb begin
    case (num)
      `CSR_CRMD:   csr_rvalue = crmd;
      `CSR_PRMD:   csr_rvalue = prmd;
      `CSR_ESTAT:  csr_rvalue = estat;
      `CSR_ERA:    csr_rvalue = era;
      `CSR_BADV:   csr_rvalue = badv;
      `CSR_EENTRY: csr_rvalue = eentry;
      default:     csr_rvalue = '0;
    endcase
  end

  assign flush.valid  = csr_req.ex | csr_req.ertn;
  assign flush.target = csr_req.ex ? eentry : era;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd   <= '0;
      prmd   <= '0;
      estat  <= '0;
      era    <= '0;
      badv   <= '0;
      eentry <= '0;
    end else if (csr_req.ex) begin
      // exception entry, save mode and drop to plv0
      prmd[`CSR_PLV_IE]     <= crmd[`CSR_PLV_IE];
      crmd[`CSR_PLV_IE]     <= '0;
      estat[`ESTAT_ECODE]    <= csr_req.ecode;
      estat[`ESTAT_ESUBCODE] <= csr_req.esubcode;
      era                    <= csr_req.pc;
      if (badv_we) begin
        badv <= csr_req.vaddr;
      end
    end else begin
      if (wr_en) begin
        case (num)
          `CSR_CRMD:   crmd   <= merge(crmd, wmask, wvalue);
          `CSR_PRMD:   prmd   <= merge(prmd, wmask, wvalue);
          `CSR_ESTAT:  estat  <= merge(estat, wmask, wvalue);
          `CSR_ERA:    era    <= merge(era, wmask, wvalue);
          `CSR_BADV:   badv   <= merge(badv, wmask, wvalue);
          `CSR_EENTRY: eentry <= merge(eentry, wmask, wvalue);
          default: ;
        endcase
      end
      // ertn restores the saved mode
      if (csr_req.ertn) begin
        crmd[`CSR_PLV_IE] <= prmd[`CSR_PLV_IE];
      end
    end
  end

  // upstream never pairs a csr write with ertn
  a_no_write_on_flush: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !flush.valid
  ) else $error("csr write applied in a flush cycle");

  a_plv_cleared: assert property (
    @(posedge clk) disable iff (!rst_n)
    csr_req.ex |=> (crmd[`CRMD_PLV] == 2'b00)
  ) else $error("crmd plv not cleared after exception entry");

endmodule

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_stage (
  input  wire logic                valid,
  input  wire wb_pkg::mem_wb_bus_t mem_bus,
  input  wire wb_pkg::word_t       csr_rvalue,
  output wb_pkg::rf_wr_t           rf_wr,
  output wb_pkg::wb_bypass_t       bypass,
  output wb_pkg::debug_wb_t        debug,
  output wb_pkg::wb_csr_t          csr_req
);
  import wb_pkg::*;

  logic      ex;
  logic      wr_en;
  word_t     wdata;
  ecode_t    ecode;
  esubcode_t esubcode;

  function automatic ecode_t ecode_of(input int bit_pos);
    case (bit_pos)
      `EBUS_INT:  return `ECODE_INT;
      `EBUS_PIL:  return `ECODE_PIL;
      `EBUS_PIS:  return `ECODE_PIS;
      `EBUS_PIF:  return `ECODE_PIF;
      `EBUS_PME:  return `ECODE_PME;
      `EBUS_PPI:  return `ECODE_PPI;
      `EBUS_ADEF: return `ECODE_ADE;
      `EBUS_ADEM: return `ECODE_ADE;
      `EBUS_ALE:  return `ECODE_ALE;
      `EBUS_SYS:  return `ECODE_SYS;
      `EBUS_BRK:  return `ECODE_BRK;
      `EBUS_INE:  return `ECODE_INE;
      `EBUS_IPE:  return `ECODE_IPE;
      `EBUS_FPD:  return `ECODE_FPD;
      `EBUS_FPE:  return `ECODE_FPE;
      `EBUS_TLBR: return `ECODE_TLBR;
      default:    return '0;
    endcase
  endfunction

  assign ex    = valid & (|mem_bus.ebus);
  assign wdata = mem_bus.res_from_csr ? csr_rvalue : mem_bus.final_result;
  // no commit for a faulting entry
  assign wr_en = valid & mem_bus.rf_we & ~ex;

  // scan from the top so the lowest set bit is left standing
  always_comb begin
    ecode    = `ECODE_INT;
    esubcode = '0;
    for (int i = `EBUS_W - 1; i >= 0; i--) begin
      if (mem_bus.ebus[i]) begin
        ecode    = ecode_of(i);
        esubcode = (i == `EBUS_ADEM) ? `ESUBCODE_ADEM : '0;
      end
    end
  end

  // only an interrupt may encode to zero
  always_comb begin
    if (ex) begin
      assert (ecode != '0 || mem_bus.ebus[`EBUS_INT])
        else $error("exception flagged with a zero ecode");
    end
  end

  assign rf_wr = '{we: wr_en, waddr: mem_bus.rf_waddr, wdata: wdata};

  assign bypass = '{
    res_from_csr: mem_bus.res_from_csr,
    waddr:        mem_bus.rf_waddr,
    we:           wr_en,
    wdata:        wdata
  };

  assign debug = '{
    pc:    mem_bus.pc,
    rf_we: {4{wr_en}},
    wnum:  mem_bus.rf_waddr,
    wdata: wdata
  };

  always_comb begin
    csr_req.ertn        = valid & mem_bus.ertn;
    csr_req.ex          = ex;
    csr_req.ecode       = ecode;
    csr_req.esubcode    = esubcode;
    csr_req.pc          = mem_bus.pc;
    // bad address comes through the result path
    csr_req.vaddr       = mem_bus.final_result;
    csr_req.csr_ctrl    = mem_bus.csr_ctrl;
    csr_req.csr_ctrl.we = valid & mem_bus.csr_ctrl.we & ~ex;
  end

endmodule

`default_nettype wire

// File: wb_pkg.sv
`default_nettype none

`include "wb_defs.svh"

package wb_pkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
  typedef logic [`EBUS_W-1:0]     ebus_t;
  typedef logic [`ECODE_W-1:0]    ecode_t;
  typedef logic [`ESUBCODE_W-1:0] esubcode_t;

  // csr access carried down the pipe, 79 bits
  typedef struct packed {
    csr_num_t num;
    logic     we;
    word_t    wmask;
    word_t    wvalue;
  } csr_ctrl_t;

  // memory stage to write-back
  typedef struct packed {
    ebus_t     ebus;
    logic      ertn;
    csr_ctrl_t csr_ctrl;
    logic      res_from_csr;
    word_t     final_result;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     pc;
  } mem_wb_bus_t;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

  // hazard bypass towards decode
  typedef struct packed {
    logic      res_from_csr;
    reg_addr_t waddr;
    logic      we;
    word_t     wdata;
  } wb_bypass_t;

  // csr_ctrl.we already qualified by valid and no exception
  typedef struct packed {
    logic      ertn;
    logic      ex;
    ecode_t    ecode;
    esubcode_t esubcode;
    word_t     pc;
    word_t     vaddr;
    csr_ctrl_t csr_ctrl;
  } wb_csr_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } flush_t;

  typedef struct packed {
    word_t      pc;
    logic [3:0] rf_we;
    reg_addr_t  wnum;
    word_t      wdata;
  } debug_wb_t;

endpackage

`default_nettype wire

// File: wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// widths
`define WORD_W        32
`define REG_ADDR_W    5
`define CSR_NUM_W     14
`define EBUS_W        16
`define ECODE_W       6
`define ESUBCODE_W    9
`define RF_DEPTH      32

// exception bus bit positions, lowest set bit wins
`define EBUS_INT      0
`define EBUS_PIL      1
`define EBUS_PIS      2
`define EBUS_PIF      3
`define EBUS_PME      4
`define EBUS_PPI      5
`define EBUS_ADEF     6
`define EBUS_ADEM     7
`define EBUS_ALE      8
`define EBUS_SYS      9
`define EBUS_BRK      10
`define EBUS_INE      11
`define EBUS_IPE      12
`define EBUS_FPD      13
`define EBUS_FPE      14
`define EBUS_TLBR     15

// exception codes
`define ECODE_INT     6'h00
`define ECODE_PIL     6'h01
`define ECODE_PIS     6'h02
`define ECODE_PIF     6'h03
`define ECODE_PME     6'h04
`define ECODE_PPI     6'h07
`define ECODE_ADE     6'h08
`define ECODE_ALE     6'h09
`define ECODE_SYS     6'h0b
`define ECODE_BRK     6'h0c
`define ECODE_INE     6'h0d
`define ECODE_IPE     6'h0e
`define ECODE_FPD     6'h0f
`define ECODE_FPE     6'h12
`define ECODE_TLBR    6'h3f

`define ESUBCODE_ADEM 9'h001

// csr numbers
`define CSR_CRMD      14'h000
`define CSR_PRMD      14'h001
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_BADV      14'h007
`define CSR_EENTRY    14'h00c

// csr field ranges
`define CSR_PLV_IE    2:0
`define CRMD_PLV      1:0
`define ESTAT_ECODE   21:16
`define ESTAT_ESUBCODE 30:22

`endif
